// File: logic/mem_addr_pkg.sv
package mem_addr_pkg;

    // physical request address as seen by the load/store queue
    localparam int PHYS_ADDR_BITS = 15;

    // byte offset within a 16-byte line
    localparam int LINE_OFFSET_BITS = 4;

    localparam int LINE_ADDR_BITS = PHYS_ADDR_BITS - LINE_OFFSET_BITS;

    typedef logic [PHYS_ADDR_BITS-1:0] phys_addr_t;

    // bits 14:4 of the physical address
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;

endpackage

// File: logic/miss_dispatch.sv
module miss_dispatch (
    input  logic                     clk,
    input  logic                     arst_n,

    input  logic                     req_valid,
    input  mem_addr_pkg::phys_addr_t req_addr,
    input  logic                     mshr_hit,
    input  logic                     mshr_full,

    output logic                     alloc,
    output logic                     req_merged,
    output logic                     req_rejected,
    output logic                     mem_rd_valid,
    output mem_addr_pkg::line_addr_t mem_rd_addr
);

    logic                     merge;
    logic                     reject;
    mem_addr_pkg::line_addr_t req_line;

    assign req_line = req_addr[mem_addr_pkg::PHYS_ADDR_BITS-1:mem_addr_pkg::LINE_OFFSET_BITS];

    // a hit always merges, full only matters for a new line
    assign merge  = req_valid & mshr_hit;
    assign reject = req_valid & ~mshr_hit & mshr_full;
    assign alloc  = req_valid & ~mshr_hit & ~mshr_full;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_merged   <= 1'b0;
            req_rejected <= 1'b0;
            mem_rd_valid <= 1'b0;
        end else begin
            req_merged   <= merge;
            req_rejected <= reject;
            mem_rd_valid <= alloc;
        end
    end

    // line address of the outgoing read
    always_ff @(posedge clk) begin
        if (alloc) begin
            mem_rd_addr <= req_line;
        end
    end

endmodule

// File: logic/mshr.sv
module mshr (
    input  logic                     clk,
    input  logic                     arst_n,

    input  logic                     req_valid,
    input  mem_addr_pkg::phys_addr_t req_addr,
    input  logic                     req_is_store,
    input  mshr_pkg::qslot_idx_t     req_qslot,
    input  logic                     alloc,
    input  logic                     fill_valid,

    output logic                     mshr_hit,
    output logic                     mshr_full,

    output logic                     wakeup_valid,
    output mem_addr_pkg::line_addr_t wakeup_addr,
    output mshr_pkg::qslot_mask_t    wakeup_rd_slots,
    output mshr_pkg::qslot_mask_t    wakeup_st_slots
);

    mem_addr_pkg::line_addr_t                                req_line;
    mshr_pkg::qslot_mask_t                                   slot_onehot;
    mshr_pkg::qslot_mask_t                                   rd_mask;
    mshr_pkg::qslot_mask_t                                   st_mask;

    mshr_pkg::entry_vec_t                                    entry_valid;
    mem_addr_pkg::line_addr_t [mshr_pkg::MSHR_ENTRIES-1:0]   entry_addr;
    mshr_pkg::entry_idx_t                                    head_idx;
    mem_addr_pkg::line_addr_t                                head_addr;
    mshr_pkg::qslot_mask_t                                   head_rd_slots;
    mshr_pkg::qslot_mask_t                                   head_st_slots;

    mshr_pkg::entry_vec_t                                    exclude;
    mshr_pkg::entry_vec_t                                    hit_vec;
    mshr_pkg::entry_vec_t                                    modify;

    assign req_line = req_addr[mem_addr_pkg::PHYS_ADDR_BITS-1:mem_addr_pkg::LINE_OFFSET_BITS];

    // slot decode, steered to the read or store lane
    assign slot_onehot = mshr_pkg::qslot_mask_t'(1) << req_qslot;
    assign rd_mask     = req_is_store ? '0 : slot_onehot;
    assign st_mask     = req_is_store ? slot_onehot : '0;

    // head leaving this cycle must not take a merge
    assign exclude = fill_valid ? (mshr_pkg::entry_vec_t'(1) << head_idx) : '0;

    assign modify = req_valid ? hit_vec : '0;

    mshr_addr_match u_match (
        .lookup_addr (req_line),
        .entry_addr  (entry_addr),
        .entry_valid (entry_valid),
        .exclude     (exclude),
        .hit_vec     (hit_vec),
        .hit         (mshr_hit)
    );

    mshr_entry_queue u_queue (
        .clk             (clk),
        .arst_n          (arst_n),
        .push            (alloc),
        .push_addr       (req_line),
        .push_rd_slots   (rd_mask),
        .push_st_slots   (st_mask),
        .pop             (fill_valid),
        .modify          (modify),
        .modify_rd_slots (rd_mask),
        .modify_st_slots (st_mask),
        .entry_valid     (entry_valid),
        .entry_addr      (entry_addr),
        .head_idx        (head_idx),
        .head_addr       (head_addr),
        .head_rd_slots   (head_rd_slots),
        .head_st_slots   (head_st_slots),
        .full            (mshr_full)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wakeup_valid <= 1'b0;
        end else begin
            wakeup_valid <= fill_valid;
        end
    end

    // snapshot of the released entry
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            wakeup_addr     <= head_addr;
            wakeup_rd_slots <= head_rd_slots;
            wakeup_st_slots <= head_st_slots;
        end
    end

endmodule

// File: logic/mshr_addr_match.sv
module mshr_addr_match (
    input  mem_addr_pkg::line_addr_t                              lookup_addr,
    input  mem_addr_pkg::line_addr_t [mshr_pkg::MSHR_ENTRIES-1:0] entry_addr,
    input  mshr_pkg::entry_vec_t                                  entry_valid,
    input  mshr_pkg::entry_vec_t                                  exclude,

    output mshr_pkg::entry_vec_t                                  hit_vec,
    output logic                                                  hit
);

    // one comparator per entry
    for (genvar i = 0; i < mshr_pkg::MSHR_ENTRIES; i++) begin : g_cmp
        assign hit_vec[i] = entry_valid[i] & ~exclude[i] & (entry_addr[i] == lookup_addr);
    end

    // merging keeps lines unique, so at most one bit is set
    assign hit = |hit_vec;

endmodule

// File: logic/mshr_entry_queue.sv
module mshr_entry_queue (
    input  logic                                            clk,
    input  logic                                            arst_n,

    input  logic                                            push,
    input  mem_addr_pkg::line_addr_t                        push_addr,
    input  mshr_pkg::qslot_mask_t                           push_rd_slots,
    input  mshr_pkg::qslot_mask_t                           push_st_slots,

    input  logic                                            pop,

    input  mshr_pkg::entry_vec_t                            modify,
    input  mshr_pkg::qslot_mask_t                           modify_rd_slots,
    input  mshr_pkg::qslot_mask_t                           modify_st_slots,

    output mshr_pkg::entry_vec_t                            entry_valid,
    output mem_addr_pkg::line_addr_t [mshr_pkg::MSHR_ENTRIES-1:0] entry_addr,
    output mshr_pkg::entry_idx_t                            head_idx,
    output mem_addr_pkg::line_addr_t                        head_addr,
    output mshr_pkg::qslot_mask_t                           head_rd_slots,
    output mshr_pkg::qslot_mask_t                           head_st_slots,
    output logic                                            full
);

    mshr_pkg::entry_vec_t                                  valid_q;
    mem_addr_pkg::line_addr_t [mshr_pkg::MSHR_ENTRIES-1:0] addr_q;
    mshr_pkg::qslot_mask_t                                 rd_slots_q [mshr_pkg::MSHR_ENTRIES];
    mshr_pkg::qslot_mask_t                                 st_slots_q [mshr_pkg::MSHR_ENTRIES];

    mshr_pkg::entry_idx_t                                  head_q;
    mshr_pkg::entry_idx_t                                  tail_q;
    mshr_pkg::entry_cnt_t                                  count_q;

    logic                                                  push_ok;
    logic                                                  pop_ok;

    assign full = (count_q == mshr_pkg::entry_cnt_t'(mshr_pkg::MSHR_ENTRIES));

    // guard against overrun and popping an empty head
    assign push_ok = push & ~full;
    assign pop_ok  = pop & valid_q[head_q];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (pop_ok) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
            if (push_ok) begin
                valid_q[tail_q] <= 1'b1;
                tail_q          <= tail_q + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // tail is invalid, so a push never collides with a modify
    always_ff @(posedge clk) begin
        for (int i = 0; i < mshr_pkg::MSHR_ENTRIES; i++) begin
            if (push_ok && tail_q == mshr_pkg::entry_idx_t'(i)) begin
                addr_q[i]     <= push_addr;
                rd_slots_q[i] <= push_rd_slots;
                st_slots_q[i] <= push_st_slots;
            end else if (modify[i]) begin
                rd_slots_q[i] <= rd_slots_q[i] | modify_rd_slots;
                st_slots_q[i] <= st_slots_q[i] | modify_st_slots;
            end
        end
    end

    assign entry_valid   = valid_q;
    assign entry_addr    = addr_q;
    assign head_idx      = head_q;
    assign head_addr     = addr_q[head_q];
    assign head_rd_slots = rd_slots_q[head_q];
    assign head_st_slots = st_slots_q[head_q];

endmodule

// File: logic/mshr_pkg.sv
package mshr_pkg;

    // entry geometry
    localparam int MSHR_ENTRIES = 8;
    localparam int ENTRY_IDX_BITS = $clog2(MSHR_ENTRIES);

    typedef logic [ENTRY_IDX_BITS-1:0] entry_idx_t;
    typedef logic [MSHR_ENTRIES-1:0] entry_vec_t;

    // occupancy, one extra bit to tell full from empty
    typedef logic [ENTRY_IDX_BITS:0] entry_cnt_t;

    // load/store queue slots
    localparam int QSLOTS = 8;
    localparam int QSLOT_IDX_BITS = $clog2(QSLOTS);

    typedef logic [QSLOT_IDX_BITS-1:0] qslot_idx_t;

    // one-hot on a request, merged inside an entry
    typedef logic [QSLOTS-1:0] qslot_mask_t;

endpackage

// File: logic/mshr_subsystem.sv
module mshr_subsystem (
    input  logic                     clk,
    input  logic                     arst_n,

    input  logic                     req_valid,
    input  mem_addr_pkg::phys_addr_t req_addr,
    input  logic                     req_is_store,
    input  mshr_pkg::qslot_idx_t     req_qslot,

    input  logic                     fill_valid,

    output logic                     req_merged,
    output logic                     req_rejected,

    output logic                     mem_rd_valid,
    output mem_addr_pkg::line_addr_t mem_rd_addr,

    output logic                     wakeup_valid,
    output mem_addr_pkg::line_addr_t wakeup_addr,
    output mshr_pkg::qslot_mask_t    wakeup_rd_slots,
    output mshr_pkg::qslot_mask_t    wakeup_st_slots,

    output logic                     mshr_full,
    output logic                     mshr_hit
);

    logic alloc;

    miss_dispatch u_dispatch (
        .clk          (clk),
        .arst_n       (arst_n),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .mshr_hit     (mshr_hit),
        .mshr_full    (mshr_full),
        .alloc        (alloc),
        .req_merged   (req_merged),
        .req_rejected (req_rejected),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_addr  (mem_rd_addr)
    );

    mshr u_mshr (
        .clk             (clk),
        .arst_n          (arst_n),
        .req_valid       (req_valid),
        .req_addr        (req_addr),
        .req_is_store    (req_is_store),
        .req_qslot       (req_qslot),
        .alloc           (alloc),
        .fill_valid      (fill_valid),
        .mshr_hit        (mshr_hit),
        .mshr_full       (mshr_full),
        .wakeup_valid    (wakeup_valid),
        .wakeup_addr     (wakeup_addr),
        .wakeup_rd_slots (wakeup_rd_slots),
        .wakeup_st_slots (wakeup_st_slots)
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module mshr_tb \
    -f src.f --Mdir obj_dir -o mshr_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/mshr_sim +verilator+error+limit+1000 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1

// File: src.f
logic/mem_addr_pkg.sv
logic/mshr_pkg.sv
logic/mshr_addr_match.sv
logic/mshr_entry_queue.sv
logic/mshr.sv
logic/miss_dispatch.sv
logic/mshr_subsystem.sv
testbench/tb_clock_gen.sv
testbench/mshr_assert.sv
testbench/mshr_tb.sv

// File: testbench/mshr_assert.sv
module mshr_assert (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     req_valid,
    input mem_addr_pkg::phys_addr_t req_addr,
    input logic                     fill_valid,
    input logic                     req_merged,
    input logic                     req_rejected,
    input logic                     mem_rd_valid,
    input mem_addr_pkg::line_addr_t mem_rd_addr,
    input logic                     wakeup_valid,
    input logic                     mshr_full,
    input logic                     mshr_hit
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned              fail_count = 0;
    int unsigned              occupancy;
    logic                     new_line;
    logic                     any_result;
    mem_addr_pkg::line_addr_t req_line;

    // line address is bits 14:4
    assign req_line   = req_addr[14:4];
    assign new_line   = req_valid & ~mshr_hit & ~mshr_full;
    assign any_result = mem_rd_valid | req_merged | req_rejected;

    // valid entries at the end of the previous cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + (new_line ? 1 : 0)
                         - ((fill_valid && occupancy != 0) ? 1 : 0);
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        new_line |=> mem_rd_valid && mem_rd_addr == $past(req_line))
    else begin
        fail_count++;
        $error("new line did not issue a memory read for its line address");
    end

    // merge wins even when full
    assert property (@(posedge clk) disable iff (!arst_n)
        req_valid && mshr_hit |=> req_merged && !mem_rd_valid)
    else begin
        fail_count++;
        $error("request to a tracked line did not merge");
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        req_valid && !mshr_hit && mshr_full |=> req_rejected)
    else begin
        fail_count++;
        $error("miss to an untracked line with all entries busy was not rejected");
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        req_valid |=> $onehot({mem_rd_valid, req_merged, req_rejected}))
    else begin
        fail_count++;
        $error("request was not followed by exactly one result strobe");
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        !req_valid |=> !any_result)
    else begin
        fail_count++;
        $error("result strobe without a request");
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        fill_valid |=> wakeup_valid)
    else begin
        fail_count++;
        $error("fill was not followed by a wakeup");
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        fill_valid |-> occupancy != 0)
    else begin
        fail_count++;
        $error("fill arrived while no entry was valid");
    end

endmodule

// File: testbench/mshr_tb.sv
module mshr_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int POOL_LINES    = 11;
    localparam int RANDOM_CYCLES = 400;
    localparam int WAIT_LIMIT    = 20;

    logic                     clk;
    logic                     arst_n;
    logic                     req_valid;
    mem_addr_pkg::phys_addr_t req_addr;
    logic                     req_is_store;
    mshr_pkg::qslot_idx_t     req_qslot;
    logic                     fill_valid;
    logic                     req_merged;
    logic                     req_rejected;
    logic                     mem_rd_valid;
    mem_addr_pkg::line_addr_t mem_rd_addr;
    logic                     wakeup_valid;
    mem_addr_pkg::line_addr_t wakeup_addr;
    mshr_pkg::qslot_mask_t    wakeup_rd_slots;
    mshr_pkg::qslot_mask_t    wakeup_st_slots;
    logic                     mshr_full;
    logic                     mshr_hit;

    // reference entries, oldest first
    mem_addr_pkg::line_addr_t model_addr [$];
    mshr_pkg::qslot_mask_t    model_rd [$];
    mshr_pkg::qslot_mask_t    model_st [$];

    // expected one cycle after the last stimulus
    logic                     exp_rd     = 1'b0;
    logic                     exp_merge  = 1'b0;
    logic                     exp_reject = 1'b0;
    logic                     exp_wake   = 1'b0;
    mem_addr_pkg::line_addr_t exp_rd_addr;
    mem_addr_pkg::line_addr_t exp_wake_addr;
    mshr_pkg::qslot_mask_t    exp_wake_rd;
    mshr_pkg::qslot_mask_t    exp_wake_st;

    logic [31:0]              rng_state = 32'hc4f9d394;
    int                       err_count = 0;
    logic                     timed_out = 1'b0;

    tb_clock_gen u_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    mshr_subsystem i_dut (
        .clk             (clk),
        .arst_n          (arst_n),
        .req_valid       (req_valid),
        .req_addr        (req_addr),
        .req_is_store    (req_is_store),
        .req_qslot       (req_qslot),
        .fill_valid      (fill_valid),
        .req_merged      (req_merged),
        .req_rejected    (req_rejected),
        .mem_rd_valid    (mem_rd_valid),
        .mem_rd_addr     (mem_rd_addr),
        .wakeup_valid    (wakeup_valid),
        .wakeup_addr     (wakeup_addr),
        .wakeup_rd_slots (wakeup_rd_slots),
        .wakeup_st_slots (wakeup_st_slots),
        .mshr_full       (mshr_full),
        .mshr_hit        (mshr_hit)
    );

    bind mshr_subsystem mshr_assert u_assert (
        .clk          (clk),
        .arst_n       (arst_n),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .fill_valid   (fill_valid),
        .req_merged   (req_merged),
        .req_rejected (req_rejected),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_addr  (mem_rd_addr),
        .wakeup_valid (wakeup_valid),
        .mshr_full    (mshr_full),
        .mshr_hit     (mshr_hit)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // small pool of lines so that merges and a full MSHR both happen
    function automatic mem_addr_pkg::phys_addr_t pool_addr(
        input int                                       idx,
        input logic [mem_addr_pkg::LINE_OFFSET_BITS-1:0] offset
    );
        mem_addr_pkg::line_addr_t line;
        line = mem_addr_pkg::line_addr_t'(idx * 97 + 3);
        return {line, offset};
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            err_count++;
            $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic check_outputs();
        expect_eq("mem_rd_valid", 32'(exp_rd), 32'(mem_rd_valid));
        expect_eq("req_merged", 32'(exp_merge), 32'(req_merged));
        expect_eq("req_rejected", 32'(exp_reject), 32'(req_rejected));
        expect_eq("wakeup_valid", 32'(exp_wake), 32'(wakeup_valid));
        if (exp_rd) begin
            expect_eq("mem_rd_addr", 32'(exp_rd_addr), 32'(mem_rd_addr));
        end
        if (exp_wake) begin
            expect_eq("wakeup_addr", 32'(exp_wake_addr), 32'(wakeup_addr));
            expect_eq("wakeup_rd_slots", 32'(exp_wake_rd), 32'(wakeup_rd_slots));
            expect_eq("wakeup_st_slots", 32'(exp_wake_st), 32'(wakeup_st_slots));
        end
    endtask

    // check the previous cycle, drive one cycle and advance the model
    task automatic apply(input logic rv, input mem_addr_pkg::phys_addr_t addr, input logic st,
                         input mshr_pkg::qslot_idx_t slot, input logic fv);
        mem_addr_pkg::line_addr_t line;
        mshr_pkg::qslot_mask_t    onehot;
        int                       hit_idx;
        logic                     exp_hit;
        logic                     exp_full;
        check_outputs();
        req_valid    = rv;
        req_addr     = addr;
        req_is_store = st;
        req_qslot    = slot;
        fill_valid   = fv;
        line         = addr[14:4];
        onehot       = mshr_pkg::qslot_mask_t'(1) << slot;
        hit_idx      = -1;
        // the head released by this fill takes no merge
        for (int i = 0; i < model_addr.size(); i++) begin
            if (model_addr[i] == line && !(fv && i == 0)) begin
                hit_idx = i;
            end
        end
        exp_hit    = (hit_idx >= 0);
        exp_full   = (model_addr.size() == mshr_pkg::MSHR_ENTRIES);
        exp_rd     = 1'b0;
        exp_merge  = 1'b0;
        exp_reject = 1'b0;
        exp_wake   = fv;
        if (rv && hit_idx >= 0) begin
            exp_merge = 1'b1;
            if (st) begin
                model_st[hit_idx] = model_st[hit_idx] | onehot;
            end else begin
                model_rd[hit_idx] = model_rd[hit_idx] | onehot;
            end
        end else if (rv && model_addr.size() == mshr_pkg::MSHR_ENTRIES) begin
            exp_reject = 1'b1;
        end else if (rv) begin
            exp_rd      = 1'b1;
            exp_rd_addr = line;
            model_addr.push_back(line);
            model_rd.push_back(st ? '0 : onehot);
            model_st.push_back(st ? onehot : '0);
        end
        if (fv) begin
            exp_wake_addr = model_addr.pop_front();
            exp_wake_rd   = model_rd.pop_front();
            exp_wake_st   = model_st.pop_front();
        end
        // status is combinational on this request, settled well before the rising edge
        #1;
        expect_eq("mshr_full", 32'(exp_full), 32'(mshr_full));
        if (rv) begin
            expect_eq("mshr_hit", 32'(exp_hit), 32'(mshr_hit));
        end
        @(negedge clk);
    endtask

    task automatic wait_for_reset();
        int n;
        n = 0;
        while (arst_n !== 1'b1 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (arst_n !== 1'b1) begin
            timed_out = 1'b1;
            $display("timeout: reset was never released");
        end else begin
            @(negedge clk);
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (model_addr.size() != 0 && n < WAIT_LIMIT) begin
            apply(1'b0, '0, 1'b0, '0, 1'b1);
            n++;
        end
        if (model_addr.size() != 0) begin
            timed_out = 1'b1;
            $display("timeout: entries still valid after %0d fills", WAIT_LIMIT);
        end
    endtask

    task automatic random_traffic(input int cycles);
        logic [31:0] r;
        logic        rv;
        logic        fv;
        for (int n = 0; n < cycles; n++) begin
            r  = next_rand();
            rv = (r[31:29] != 3'd0);
            fv = (model_addr.size() != 0) && (r[28:27] == 2'd0);
            apply(rv, pool_addr(int'(r[26:16]) % POOL_LINES, r[15:12]), r[11], r[10:8], fv);
        end
    endtask

    task automatic full_mshr_case();
        drain();
        for (int i = 0; i < mshr_pkg::MSHR_ENTRIES; i++) begin
            apply(1'b1, pool_addr(i, 4'h0), 1'b0, mshr_pkg::qslot_idx_t'(i), 1'b0);
        end
        apply(1'b1, pool_addr(8, 4'h5), 1'b0, 3'd1, 1'b0);
        apply(1'b1, pool_addr(3, 4'ha), 1'b1, 3'd6, 1'b0);
        // released space is not free yet, so this one is rejected
        apply(1'b1, pool_addr(0, 4'h2), 1'b0, 3'd2, 1'b1);
        apply(1'b1, pool_addr(1, 4'h7), 1'b1, 3'd4, 1'b1);
        drain();
    endtask

    initial begin
        int assert_fails;
        req_valid    = 1'b0;
        req_addr     = '0;
        req_is_store = 1'b0;
        req_qslot    = '0;
        fill_valid   = 1'b0;
        wait_for_reset();
        if (!timed_out) begin
            expect_eq("mshr_full", 32'd0, 32'(mshr_full));
            random_traffic(RANDOM_CYCLES);
            full_mshr_case();
            apply(1'b0, '0, 1'b0, '0, 1'b0);
        end
        assert_fails = i_dut.u_assert.fail_count;
        $display("errors: %0d model mismatches, %0d assertion failures", err_count, assert_fails);
        if (timed_out || err_count != 0 || assert_fails != 0) begin
            $display("Simulation FAILED");
        end else begin
            $display("Simulation PASSED");
        end
        $finish;
    end

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // three cycles of reset, released away from the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule
